/* rtl/bg_layer.sv */
// ------------------------------
// Background layer, four 160x120 one-bit pages
// Output bit is one cycle behind the counts
// ------------------------------
`timescale 1ns/1ps

module bg_layer (
	input  logic                    clk25,
	input  vga_timing_pkg::hcount_t hcount,
	input  vga_timing_pkg::vcount_t vcount,
	input  gfx_pkg::page_t          page,     // Displayed page
	input  logic                    we,
	input  gfx_pkg::pic_addr_t      wr_addr,  // page*19200 + ly*160 + lx
	input  logic                    wr_data,
	output logic                    bg_pixel
);

	import vga_timing_pkg::*;
	import gfx_pkg::*;

	hcount_t   h_scaled; // Counts divided by 4
	vcount_t   v_scaled;
	lx_t       lx;
	ly_t       ly;
	pic_addr_t rd_addr;

	assign h_scaled = hcount >> SCALE_SHIFT;
	assign v_scaled = vcount >> SCALE_SHIFT;

	// Clamp in blanking, pixel gets blanked downstream
	assign lx = (hcount < H_ACTIVE) ? lx_t'(h_scaled) : lx_t'(LX_MAX - 1);
	assign ly = (vcount < V_ACTIVE) ? ly_t'(v_scaled) : ly_t'(LY_MAX - 1);

	// Same layout as the host write address
	assign rd_addr = pic_addr_t'(page) * pic_addr_t'(PAGE_PIXELS)
		+ pic_addr_t'(ly) * pic_addr_t'(LX_MAX)
		+ pic_addr_t'(lx);

	bitmap_ram #(
		.DEPTH (PAGE_PIXELS * BG_PAGES)
	) u_bg_ram (
		.clk25   (clk25),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (bg_pixel)  // Registered, lines up with sprite hits
	);

endmodule

/* rtl/bitmap_ram.sv */
// ------------------------------
// One-bit bitmap memory, host write port plus registered read
// ------------------------------
`timescale 1ns/1ps

module bitmap_ram #(
	parameter int DEPTH = 1024 // 76800, 256 or 1024 bits
) (
	input  logic              clk25,
	input  logic              we,
	input  gfx_pkg::pic_addr_t wr_addr,
	input  logic              wr_data,
	input  gfx_pkg::pic_addr_t rd_addr,
	output logic              rd_data
);

	localparam int AW = $clog2(DEPTH); // Index bits actually used

	logic mem [DEPTH];

	// Host load port
	always_ff @(posedge clk25) begin
		if (we)
			mem[wr_addr[AW-1:0]] <= wr_data;
	end

	// Read sees the old bit on a same-address write
	always_ff @(posedge clk25) begin
		rd_data <= mem[rd_addr[AW-1:0]];
	end

	// Host must stay inside this memory
	a_wr_in_range: assert property (
		@(posedge clk25) we |-> (wr_addr < DEPTH)
	) else $error("bitmap write beyond depth %0d", DEPTH);

endmodule

/* rtl/gfx_pkg.sv */
// ------------------------------
// Logical screen, bitmap, sprite and colour definitions
// ------------------------------
package gfx_pkg;

	// One logical pixel covers 4x4 screen pixels
	localparam int SCALE_SHIFT = 2;

	// Logical screen size
	localparam int LX_MAX = 160;
	localparam int LY_MAX = 120;

	// Background bitmap, one bit per logical pixel
	localparam int PAGE_PIXELS = LX_MAX * LY_MAX; // 19200
	localparam int BG_PAGES    = 4;

	// Sprite edges and pattern frames
	localparam int SP1_SIZE  = 8;
	localparam int SP2_SIZE  = 16;
	localparam int SP_FRAMES = 4;

	// Logical coordinates
	typedef logic [7:0] lx_t;   // 0 to 159 on screen
	typedef logic [6:0] ly_t;   // 0 to 119 on screen

	// Background page or sprite frame select
	typedef logic [1:0] page_t;

	// Shared write address, covers 76800 background bits
	typedef logic [16:0] pic_addr_t;

	// 4:4:4 colour, red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] rgb_t;
	typedef logic [3:0]  chan_t;

endpackage

/* rtl/pixel_mixer.sv */
// ------------------------------
// Layer priority, palette and blanking
// Colour and syncs leave together, two cycles after the counts
// ------------------------------
`timescale 1ns/1ps

module pixel_mixer (
	input  logic          clk25,
	input  logic          arst_n,
	input  logic          active,
	input  logic          hsync_n,
	input  logic          vsync_n,
	input  logic          bg_pixel,
	input  logic          sp1_hit,
	input  logic          sp1_pixel,
	input  logic          sp2_hit,
	input  logic          sp2_pixel,
	input  gfx_pkg::rgb_t color0,   // Colour for a 0 pixel
	input  gfx_pkg::rgb_t color1,   // Colour for a 1 pixel
	output gfx_pkg::chan_t vga_r,
	output gfx_pkg::chan_t vga_g,
	output gfx_pkg::chan_t vga_b,
	output logic          vga_hsync_n,
	output logic          vga_vsync_n
);

	import gfx_pkg::*;

	logic active_d;
	logic hsync_d;
	logic vsync_d;
	logic pix;      // Winning layer bit
	rgb_t rgb_next;

	// Match the one-cycle layer latency
	always_ff @(posedge clk25 or negedge arst_n) begin
		if (!arst_n) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
		end else begin
			active_d <= active;
			hsync_d  <= hsync_n;
			vsync_d  <= vsync_n;
		end
	end

	// Sprite 1 over sprite 2 over background
	assign pix = sp1_hit ? sp1_pixel : (sp2_hit ? sp2_pixel : bg_pixel);

	assign rgb_next = !active_d ? '0 : (pix ? color1 : color0);

	// Output register
	always_ff @(posedge clk25 or negedge arst_n) begin
		if (!arst_n) begin
			{vga_r, vga_g, vga_b} <= '0;
			vga_hsync_n           <= 1'b1;
			vga_vsync_n           <= 1'b1;
		end else begin
			{vga_r, vga_g, vga_b} <= rgb_next;
			vga_hsync_n           <= hsync_d;
			vga_vsync_n           <= vsync_d;
		end
	end

endmodule

/* rtl/sprite_unit.sv */
// ------------------------------
// Square one-bit sprite with four frames
// Hit and pixel both come one cycle after the counts
// ------------------------------
`timescale 1ns/1ps

module sprite_unit #(
	parameter int SIZE = 8 // Edge length, 8 or 16
) (
	input  logic                    clk25,
	input  logic                    arst_n,
	input  vga_timing_pkg::hcount_t hcount,
	input  vga_timing_pkg::vcount_t vcount,
	input  logic                    en,
	input  gfx_pkg::lx_t            pos_x,   // Top-left corner, logical units
	input  gfx_pkg::ly_t            pos_y,
	input  gfx_pkg::page_t          frame,   // Pattern frame
	input  logic                    we,
	input  gfx_pkg::pic_addr_t      wr_addr, // frame*SIZE^2 + row*SIZE + col
	input  logic                    wr_data,
	output logic                    hit,
	output logic                    pixel
);

	import gfx_pkg::*;

	localparam int SB = $clog2(SIZE);    // Bits per pattern row/column
	localparam int XW = $bits(lx_t) + 1; // One bit wider, no wrap at edges
	localparam int YW = $bits(ly_t) + 1;

	lx_t             lx;
	ly_t             ly;
	logic [XW-1:0]   x_lo, x_hi, lx_w;
	logic [YW-1:0]   y_lo, y_hi, ly_w;
	lx_t             off_x; // Offset inside the sprite
	ly_t             off_y;
	pic_addr_t       rd_addr;

	assign lx = lx_t'(hcount >> SCALE_SHIFT);
	assign ly = ly_t'(vcount >> SCALE_SHIFT);

	// Widened bounds, right/bottom edge exclusive
	assign lx_w = {1'b0, lx};
	assign ly_w = {1'b0, ly};
	assign x_lo = {1'b0, pos_x};
	assign y_lo = {1'b0, pos_y};
	assign x_hi = x_lo + XW'(SIZE);
	assign y_hi = y_lo + YW'(SIZE);

	always_ff @(posedge clk25 or negedge arst_n) begin
		if (!arst_n)
			hit <= 1'b0;
		else
			hit <= en && (lx_w >= x_lo) && (lx_w < x_hi)
				&& (ly_w >= y_lo) && (ly_w < y_hi);
	end

	// Low bits only matter while hit
	assign off_x = lx - pos_x;
	assign off_y = ly - pos_y;

	// Concatenation equals frame*SIZE^2 + row*SIZE + col
	assign rd_addr = pic_addr_t'({frame, off_y[SB-1:0], off_x[SB-1:0]});

	bitmap_ram #(
		.DEPTH (SIZE * SIZE * SP_FRAMES)
	) u_pat_ram (
		.clk25   (clk25),
		.we      (we),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (pixel)
	);

endmodule

/* rtl/vga_game_display.sv */
// ------------------------------
// Game console display top, 160x120 picture on 640x480 VGA
// Host loads bitmaps through the shared write port
// ------------------------------
`timescale 1ns/1ps

module vga_game_display (
	input  logic               clk25,
	input  logic               arst_n,
	input  gfx_pkg::rgb_t      color0,
	input  gfx_pkg::rgb_t      color1,
	input  gfx_pkg::page_t     bkg_page,
	input  logic               sp1_en,
	input  gfx_pkg::lx_t       sp1_x,
	input  gfx_pkg::ly_t       sp1_y,
	input  gfx_pkg::page_t     sp1_frame,
	input  logic               sp2_en,
	input  gfx_pkg::lx_t       sp2_x,
	input  gfx_pkg::ly_t       sp2_y,
	input  gfx_pkg::page_t     sp2_frame,
	input  logic               bkg_we,     // One enable per memory
	input  logic               sp1_we,
	input  logic               sp2_we,
	input  gfx_pkg::pic_addr_t wr_addr,
	input  logic               wr_data,
	output gfx_pkg::chan_t     vga_r,
	output gfx_pkg::chan_t     vga_g,
	output gfx_pkg::chan_t     vga_b,
	output logic               vga_hsync_n,
	output logic               vga_vsync_n,
	output logic               frame_end   // Undelayed, safe point to update controls
);

	import vga_timing_pkg::*;
	import gfx_pkg::*;

	hcount_t hcount;
	vcount_t vcount;
	logic    active, hsync_n, vsync_n; // Raw, pre-pipeline
	logic    bg_pixel;
	logic    sp1_hit, sp1_pixel;
	logic    sp2_hit, sp2_pixel;

	vga_timing u_timing (
		.clk25 (clk25), .arst_n (arst_n),
		.hcount (hcount), .vcount (vcount),
		.active (active), .hsync_n (hsync_n), .vsync_n (vsync_n),
		.frame_end (frame_end)
	);

	bg_layer u_bg (
		.clk25 (clk25), .hcount (hcount), .vcount (vcount), .page (bkg_page),
		.we (bkg_we), .wr_addr (wr_addr), .wr_data (wr_data),
		.bg_pixel (bg_pixel)
	);

	// 8x8 sprite, highest priority
	sprite_unit #(.SIZE (SP1_SIZE)) u_sp1 (
		.clk25 (clk25), .arst_n (arst_n), .hcount (hcount), .vcount (vcount),
		.en (sp1_en), .pos_x (sp1_x), .pos_y (sp1_y), .frame (sp1_frame),
		.we (sp1_we), .wr_addr (wr_addr), .wr_data (wr_data),
		.hit (sp1_hit), .pixel (sp1_pixel)
	);

	// 16x16 sprite
	sprite_unit #(.SIZE (SP2_SIZE)) u_sp2 (
		.clk25 (clk25), .arst_n (arst_n), .hcount (hcount), .vcount (vcount),
		.en (sp2_en), .pos_x (sp2_x), .pos_y (sp2_y), .frame (sp2_frame),
		.we (sp2_we), .wr_addr (wr_addr), .wr_data (wr_data),
		.hit (sp2_hit), .pixel (sp2_pixel)
	);

	pixel_mixer u_mixer (
		.clk25 (clk25), .arst_n (arst_n),
		.active (active), .hsync_n (hsync_n), .vsync_n (vsync_n),
		.bg_pixel (bg_pixel),
		.sp1_hit (sp1_hit), .sp1_pixel (sp1_pixel),
		.sp2_hit (sp2_hit), .sp2_pixel (sp2_pixel),
		.color0 (color0), .color1 (color1),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.vga_hsync_n (vga_hsync_n), .vga_vsync_n (vga_vsync_n)
	);

endmodule

/* rtl/vga_timing.sv */
// ------------------------------
// VGA raster counters and sync generation
// Counts and syncs are valid in the same cycle
// ------------------------------
`timescale 1ns/1ps

module vga_timing (
	input  logic                    clk25,
	input  logic                    arst_n,
	output vga_timing_pkg::hcount_t hcount,
	output vga_timing_pkg::vcount_t vcount,
	output logic                    active,    // Visible 640x480 area
	output logic                    hsync_n,
	output logic                    vsync_n,
	output logic                    frame_end  // One cycle at (799, 524)
);

	import vga_timing_pkg::*;

	logic h_last;   // Last pixel of a line
	logic v_last;   // Last line of the frame

	assign h_last = (hcount == H_TOTAL - 1);
	assign v_last = (vcount == V_TOTAL - 1);

	// Free-running raster counters
	always_ff @(posedge clk25 or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_last) begin
			hcount <= '0; // Wrap line
			if (v_last)
				vcount <= '0; // Wrap frame
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Flop set one pixel early so it lines up with (799, 524)
	always_ff @(posedge clk25 or negedge arst_n) begin
		if (!arst_n)
			frame_end <= 1'b0;
		else
			frame_end <= (hcount == H_TOTAL - 2) && v_last;
	end

	// Decoded straight from the counts
	assign active  = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
	assign hsync_n = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END)); // Low 656..751
	assign vsync_n = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END)); // Low 490..491

	// Counter never leaves the raster
	a_hcount_range: assert property (
		@(posedge clk25) disable iff (!arst_n)
		hcount <= H_TOTAL - 1
	) else $error("hcount beyond end of line");

	// Single-cycle frame strobe
	a_frame_end_pulse: assert property (
		@(posedge clk25) disable iff (!arst_n)
		frame_end |=> !frame_end
	) else $error("frame_end longer than one cycle");

endmodule

/* rtl/vga_timing_pkg.sv */
// ------------------------------
// VGA 640x480 raster constants and counter types
// Imported by the timing generator and the layers
// ------------------------------
package vga_timing_pkg;

	// Horizontal raster, in 25 MHz pixel clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

	// Vertical raster, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

	// Sync windows, start inclusive and end exclusive
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;     // 656
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;  // 752
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;     // 490
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;  // 492

	// Raster position, 0 to 799
	typedef logic [9:0] hcount_t;

	// Line number, 0 to 524
	typedef logic [9:0] vcount_t;

endpackage

/* tests/tb_vga_game_display.sv */
// ------------------------------
// Random self-checking testbench for the game display
// Loads all bitmaps, then checks whole frames against a model
// ------------------------------
`timescale 1ns/1ps

module tb_vga_game_display;

	import vga_timing_pkg::*;
	import gfx_pkg::*;

	localparam int BG_BITS      = PAGE_PIXELS * BG_PAGES;         // 76800
	localparam int SP1_BITS     = SP1_SIZE * SP1_SIZE * SP_FRAMES; // 256
	localparam int SP2_BITS     = SP2_SIZE * SP2_SIZE * SP_FRAMES; // 1024
	localparam int LOAD_TOTAL   = BG_BITS + SP1_BITS + SP2_BITS;
	localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;               // 420000
	localparam int CHECK_FRAMES = 3;
	localparam int WATCHDOG_NS  = (LOAD_TOTAL + 6 * FRAME_CYC) * 4;

	logic clk25 = 1'b0;
	logic arst_n;
	rgb_t color0, color1;
	page_t bkg_page, sp1_frame, sp2_frame;
	logic sp1_en, sp2_en;
	lx_t sp1_x, sp2_x;
	ly_t sp1_y, sp2_y;
	logic bkg_we, sp1_we, sp2_we, wr_data;
	pic_addr_t wr_addr;
	chan_t vga_r, vga_g, vga_b;
	logic vga_hsync_n, vga_vsync_n, frame_end;

	logic bg_mem [BG_BITS];   // Mirrors of the DUT memories
	logic sp1_mem [SP1_BITS];
	logic sp2_mem [SP2_BITS];
	logic [31:0] lfsr = 32'h32b5;
	int mh, mv;               // Model raster position
	int load_idx, frames_checked;
	logic loaded, rgb_on;
	rgb_t p0_rgb, p1_rgb;     // Two pixels in flight
	logic [1:0] p0_sync, p1_sync;
	logic p0_chk, p1_chk;
	int p0_h, p0_v, p1_h, p1_v;

	vga_game_display DUT (.*);

	always #2 clk25 = ~clk25; // 4 ns, 250 MHz sim rate

	// Galois LFSR, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic bit in_sprite(input logic en, input int px, input int py,
		input int size, input int lx, input int ly);
		return en && lx >= px && lx < px + size && ly >= py && ly < py + size; // No wrap
	endfunction

	function automatic logic [1:0] predict_sync(input int h, input int v);
		logic hs, vs;
		hs = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
		vs = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
		return {hs, vs};
	endfunction

	// Layer priority and palette from the mirrors
	function automatic rgb_t predict_rgb(input int h, input int v);
		int lx, ly;
		logic pix;
		lx = h / 4;
		ly = v / 4;
		if (h >= H_ACTIVE || v >= V_ACTIVE)
			return '0; // Blanked
		pix = bg_mem[int'(bkg_page) * PAGE_PIXELS + ly * LX_MAX + lx];
		if (in_sprite(sp2_en, int'(sp2_x), int'(sp2_y), SP2_SIZE, lx, ly))
			pix = sp2_mem[int'(sp2_frame) * 256 + (ly - int'(sp2_y)) * 16 + lx - int'(sp2_x)];
		if (in_sprite(sp1_en, int'(sp1_x), int'(sp1_y), SP1_SIZE, lx, ly))
			pix = sp1_mem[int'(sp1_frame) * 64 + (ly - int'(sp1_y)) * 8 + lx - int'(sp1_x)];
		return pix ? color1 : color0;
	endfunction

	task automatic check_rgb(input rgb_t got, input rgb_t exp, input int h, input int v);
		if (got !== exp) begin
			$display("ERROR at %0t: rgb at (%0d,%0d) is %h, expected %h", $time, h, v, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_sync(input logic [1:0] got, input logic [1:0] exp,
		input int h, input int v);
		if (got !== exp) begin
			$display("ERROR at %0t: {hsync_n,vsync_n} at (%0d,%0d) is %b, expected %b",
				$time, h, v, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: frame_end is %b, expected %b", $time, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// New layer controls, full position range
	task automatic draw_controls();
		bkg_page  = page_t'(take_bits(2));
		color0    = rgb_t'(take_bits(12));
		color1    = rgb_t'(take_bits(12));
		sp1_en    = (take_bits(2) != 0); // Mostly on
		sp1_x     = lx_t'(take_bits(8));
		sp1_y     = ly_t'(take_bits(7));
		sp1_frame = page_t'(take_bits(2));
		sp2_en    = (take_bits(2) != 0);
		if (take_bits(1) != 0) begin
			sp2_x = sp1_x - lx_t'(take_bits(3)); // Under sprite 1, priority case
			sp2_y = sp1_y - ly_t'(take_bits(3));
		end else begin
			sp2_x = lx_t'(take_bits(8));
			sp2_y = ly_t'(take_bits(7));
		end
		sp2_frame = page_t'(take_bits(2));
	endtask

	// One host write per cycle: background, then sprite 1, then sprite 2
	task automatic drive_write();
		{bkg_we, sp1_we, sp2_we} = 3'b000;
		if (load_idx < LOAD_TOTAL) begin
			wr_data = 1'(take_bits(1));
			if (load_idx < BG_BITS) begin
				wr_addr = pic_addr_t'(load_idx);
				bkg_we  = 1'b1;
				bg_mem[load_idx] = wr_data;
			end else if (load_idx < BG_BITS + SP1_BITS) begin
				wr_addr = pic_addr_t'(load_idx - BG_BITS);
				sp1_we  = 1'b1;
				sp1_mem[load_idx - BG_BITS] = wr_data;
			end else begin
				wr_addr = pic_addr_t'(load_idx - BG_BITS - SP1_BITS);
				sp2_we  = 1'b1;
				sp2_mem[load_idx - BG_BITS - SP1_BITS] = wr_data;
			end
			load_idx++;
		end else begin
			loaded = 1'b1;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: display frames did not complete within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$fatal(1);
	end

	initial begin
		arst_n = 1'b0;
		{bkg_we, sp1_we, sp2_we, wr_data} = 4'b0000;
		wr_addr = '0;
		{color0, color1, bkg_page} = '0;
		{sp1_en, sp1_x, sp1_y, sp1_frame} = '0;
		{sp2_en, sp2_x, sp2_y, sp2_frame} = '0;
		{load_idx, frames_checked, mh, mv} = '0;
		{loaded, rgb_on} = 2'b00;
		repeat (10) @(negedge clk25);
		check_sync({vga_hsync_n, vga_vsync_n}, 2'b11, -1, -1); // Reset state
		check_rgb({vga_r, vga_g, vga_b}, '0, -1, -1);
		arst_n  = 1'b1;
		p1_rgb  = '0;
		p1_sync = 2'b11;
		p1_chk  = 1'b1;
		p1_h    = -1;
		p1_v    = -1;
		p0_rgb  = predict_rgb(0, 0);
		p0_sync = predict_sync(0, 0);
		p0_chk  = 1'b0;
		p0_h    = 0;
		p0_v    = 0;
		while (frames_checked < CHECK_FRAMES) begin
			@(negedge clk25);
			if (mh == H_TOTAL - 1) begin
				mh = 0;
				mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
			end else begin
				mh++;
			end
			check_sync({vga_hsync_n, vga_vsync_n}, p1_sync, p1_h, p1_v);
			if (p1_chk)
				check_rgb({vga_r, vga_g, vga_b}, p1_rgb, p1_h, p1_v);
			check_flag(frame_end, mh == H_TOTAL - 1 && mv == V_TOTAL - 1);
			{p1_rgb, p1_sync, p1_chk, p1_h, p1_v} = {p0_rgb, p0_sync, p0_chk, p0_h, p0_v};
			p0_rgb  = predict_rgb(mh, mv);
			p0_sync = predict_sync(mh, mv);
			p0_chk  = rgb_on;
			{p0_h, p0_v} = {mh, mv};
			drive_write();
			if (frame_end) begin
				if (rgb_on)
					frames_checked++;
				rgb_on = loaded; // Next frame sees only finished memories
				draw_controls();
			end
		end
		$display("** PASS **");
		$finish;
	end

endmodule

/* verilog.f */
rtl/vga_timing_pkg.sv
rtl/gfx_pkg.sv
rtl/vga_timing.sv
rtl/bitmap_ram.sv
rtl/bg_layer.sv
rtl/sprite_unit.sv
rtl/pixel_mixer.sv
rtl/vga_game_display.sv
tests/tb_vga_game_display.sv
